// File: verilog/cart_pkg.sv
// bus types, port map and ws2812 timing for the cartridge I/O side
// LED timing counts assume clk at 42.95 MHz; only 8-bit I/O cycles are modelled
`default_nettype none

package cart_pkg;

	// -----------------------------------------------
	// widths with a meaning
	// -----------------------------------------------
	typedef logic [7:0] io_addr_t;			// z80 I/O port number
	typedef logic [7:0] io_data_t;			// slot data byte

	localparam int VRAM_AW = 10;			// 1 KiB on-chip vram
	typedef logic [VRAM_AW-1:0] vram_addr_t;

	// one request from the slot side
	typedef struct packed {
		logic     valid;
		logic     write;
		io_addr_t address;
		io_data_t wdata;
	} bus_req_t;

	// one block's answer
	typedef struct packed {
		logic     ready;
		io_data_t rdata;	// FFh while rdata_en is low
		logic     rdata_en;	// one cycle after an accepted read
	} bus_rsp_t;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} led_rgb_t;

	// -----------------------------------------------
	// port map
	// -----------------------------------------------
	localparam io_addr_t GPIO_BASE = 8'h10;	// 10h..13h
	localparam io_addr_t VDP_BASE  = 8'h98;	// 98h data, 99h setup

	// ws2812 bit timing in clk cycles
	localparam int WS_T0H    = 17;		// ~0.4 us high for a 0
	localparam int WS_T1H    = 34;		// ~0.8 us high for a 1
	localparam int WS_TBIT   = 54;		// ~1.25 us per bit
	localparam int WS_TLATCH = 2150;	// >50 us low, LED latches colour

	localparam int WS_CNT_W = $clog2(WS_TLATCH);
	typedef logic [WS_CNT_W-1:0] ws_cnt_t;	// wide enough for the latch gap

endpackage

`default_nettype wire

// File: verilog/cart_bus_ctrl.sv
// port decode and response merge; one request in flight at a time
// ports outside 10h..13h and 98h/99h are answered here with FFh
`timescale 1ns/1ps
`default_nettype none

module cart_bus_ctrl (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire cart_pkg::bus_req_t bus_req,
	input  wire cart_pkg::bus_rsp_t gpio_rsp,
	input  wire cart_pkg::bus_rsp_t vram_rsp,
	output cart_pkg::bus_rsp_t  bus_rsp,
	output cart_pkg::bus_req_t  gpio_req,
	output cart_pkg::bus_req_t  vram_req
);

	typedef enum logic {
		ST_IDLE,
		ST_WAIT_DATA	// read accepted, strobe not out yet
	} state_t;

	state_t state;
	logic   sel_gpio;
	logic   sel_vdp;
	logic   accept;
	logic   ff_en;		// registered FFh answer, unclaimed read

	// -----------------------------------------------
	// address decode
	// -----------------------------------------------
	assign sel_gpio = (bus_req.address[7:2] == cart_pkg::GPIO_BASE[7:2]);	// four ports
	assign sel_vdp  = (bus_req.address[7:1] == cart_pkg::VDP_BASE[7:1]);	// two ports

	// forward only the low bits, valid to the selected block only
	always_comb begin
		gpio_req         = bus_req;
		gpio_req.address = {6'd0, bus_req.address[1:0]};
		gpio_req.valid   = bus_req.valid & sel_gpio & (state == ST_IDLE);

		vram_req         = bus_req;
		vram_req.address = {6'd0, bus_req.address[1:0]};
		vram_req.valid   = bus_req.valid & sel_vdp & (state == ST_IDLE);
	end

	// -----------------------------------------------
	// response merge
	// -----------------------------------------------
	always_comb begin
		bus_rsp.ready = 1'b0;				// no acceptance while waiting for data
		if (state == ST_IDLE) begin
			if (sel_gpio) begin
				bus_rsp.ready = gpio_rsp.ready;
			end else if (sel_vdp) begin
				bus_rsp.ready = vram_rsp.ready;	// low during prefetch refill
			end else begin
				bus_rsp.ready = 1'b1;		// unclaimed, answered at once
			end
		end

		bus_rsp.rdata_en = gpio_rsp.rdata_en | vram_rsp.rdata_en | ff_en;
		if (gpio_rsp.rdata_en) begin
			bus_rsp.rdata = gpio_rsp.rdata;
		end else if (vram_rsp.rdata_en) begin
			bus_rsp.rdata = vram_rsp.rdata;
		end else begin
			bus_rsp.rdata = 8'hFF;			// idle bus and unclaimed reads
		end
	end

	assign accept = bus_req.valid & bus_rsp.ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			ff_en <= 1'b0;
		end else begin
			ff_en <= accept & ~bus_req.write & ~sel_gpio & ~sel_vdp;
			case (state)
				ST_IDLE: begin
					if (accept && !bus_req.write) begin
						state <= ST_WAIT_DATA;
					end
				end
				ST_WAIT_DATA: begin
					if (bus_rsp.rdata_en) begin
						state <= ST_IDLE;	// strobe leaves this cycle
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/cart_gpio.sv
// LED colour registers at offsets 0..2, send strobe and busy flag at offset 3
// always ready; read data is registered one cycle after acceptance
`timescale 1ns/1ps
`default_nettype none

module cart_gpio (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire cart_pkg::bus_req_t req,
	input  wire                 led_busy,
	output cart_pkg::bus_rsp_t  rsp,
	output logic                led_send,
	output cart_pkg::led_rgb_t  led_color
);

	cart_pkg::led_rgb_t color_q;
	cart_pkg::io_data_t rdata_q;
	logic               rdata_en_q;
	logic               wr_acc;
	logic               rd_acc;
	logic [1:0]         offset;

	// no wait states here
	assign rsp    = '{ready: 1'b1, rdata: rdata_q, rdata_en: rdata_en_q};
	assign wr_acc = req.valid & req.write;
	assign rd_acc = req.valid & ~req.write;
	assign offset = req.address[1:0];

	assign led_color = color_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			color_q    <= '0;		// LED dark until programmed
			led_send   <= 1'b0;
			rdata_en_q <= 1'b0;
			rdata_q    <= 8'hFF;
		end else begin
			led_send   <= wr_acc & (offset == 2'd3);	// data byte ignored
			rdata_en_q <= rd_acc;
			rdata_q    <= 8'hFF;

			// colour writes, also taken while a frame is running
			if (wr_acc) begin
				case (offset)
					2'd0:    color_q.red   <= req.wdata;
					2'd1:    color_q.green <= req.wdata;
					2'd2:    color_q.blue  <= req.wdata;
					default: ;
				endcase
			end

			if (rd_acc) begin
				case (offset)
					2'd0:    rdata_q <= color_q.red;
					2'd1:    rdata_q <= color_q.green;
					2'd2:    rdata_q <= color_q.blue;
					// strobe in flight already counts as busy
					default: rdata_q <= {7'd0, led_busy | led_send};
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/ws2812_tx.sv
// single-LED ws2812 serialiser: 24 bits GRB, MSB first, then the latch gap
// a send while busy is dropped; colour is sampled on the accepted send only
`timescale 1ns/1ps
`default_nettype none

module ws2812_tx (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire                 send,
	input  wire cart_pkg::led_rgb_t color,
	output logic                busy,
	output logic                led
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HIGH,	// pulse part of a bit
		ST_LOW,		// rest of the bit period
		ST_LATCH	// reset gap after the frame
	} state_t;

	state_t            state;
	logic [23:0]       shift;		// grb word, bit 23 goes out next
	logic [4:0]        bit_cnt;
	cart_pkg::ws_cnt_t timer;
	cart_pkg::ws_cnt_t t_high;		// last cycle of the high pulse

	// pulse width from the current bit
	assign t_high = shift[23] ? cart_pkg::ws_cnt_t'(cart_pkg::WS_T1H - 1)
	                          : cart_pkg::ws_cnt_t'(cart_pkg::WS_T0H - 1);

	assign busy = (state != ST_IDLE);
	assign led  = (state == ST_HIGH);

	// -----------------------------------------------
	// bit timing FSM
	// -----------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ST_IDLE;
			timer   <= '0;
			bit_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					timer   <= '0;
					bit_cnt <= '0;
					if (send) begin
						state <= ST_HIGH;	// line rises next cycle
					end
				end
				ST_HIGH: begin
					timer <= timer + 1'b1;
					if (timer == t_high) begin
						state <= ST_LOW;
					end
				end
				ST_LOW: begin
					if (timer == cart_pkg::ws_cnt_t'(cart_pkg::WS_TBIT - 1)) begin
						timer   <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						state   <= (bit_cnt == 5'd23) ? ST_LATCH : ST_HIGH;
					end else begin
						timer <= timer + 1'b1;
					end
				end
				ST_LATCH: begin
					if (timer == cart_pkg::ws_cnt_t'(cart_pkg::WS_TLATCH - 1)) begin
						state <= ST_IDLE;
					end else begin
						timer <= timer + 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// shift word, loaded on send and advanced at each bit end
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && send) begin
			shift <= {color.green, color.red, color.blue};
		end else if (state == ST_LOW
		             && timer == cart_pkg::ws_cnt_t'(cart_pkg::WS_TBIT - 1)) begin
			shift <= {shift[22:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// File: verilog/vram_port.sv
// V9958-style data (offset 0) and setup (offset 1) ports into a 1 KiB VRAM
// only address bit 0 is decoded; data writes leave the read prefetch untouched
`timescale 1ns/1ps
`default_nettype none

module vram_port (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire cart_pkg::bus_req_t req,
	output cart_pkg::bus_rsp_t  rsp
);

	typedef enum logic {
		ST_IDLE,
		ST_FETCH	// prefetch refill, back-pressure
	} state_t;

	state_t               state;
	cart_pkg::io_data_t   mem [0:(1 << cart_pkg::VRAM_AW) - 1];
	cart_pkg::vram_addr_t ptr;		// wraps at 1 KiB
	cart_pkg::vram_addr_t wr_addr;
	cart_pkg::io_data_t   wr_data;
	cart_pkg::io_data_t   addr_lo;		// first setup byte
	cart_pkg::io_data_t   prefetch;	// read-ahead latch
	cart_pkg::io_data_t   rdata_q;
	logic                 rdata_en_q;
	logic                 toggle;		// first setup byte seen
	logic                 wr_pend;
	logic                 accept;
	logic                 is_data;

	assign rsp     = '{ready: (state == ST_IDLE), rdata: rdata_q, rdata_en: rdata_en_q};
	assign accept  = req.valid & (state == ST_IDLE);
	assign is_data = ~req.address[0];	// 98h data, 99h setup

	// -----------------------------------------------
	// pointer, setup toggle, read answer
	// -----------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ST_IDLE;
			ptr        <= '0;
			addr_lo    <= '0;
			toggle     <= 1'b0;
			wr_pend    <= 1'b0;
			rdata_en_q <= 1'b0;
			rdata_q    <= 8'hFF;
		end else begin
			wr_pend    <= 1'b0;
			rdata_en_q <= 1'b0;
			rdata_q    <= 8'hFF;

			if (state == ST_FETCH) begin
				ptr   <= ptr + 1'b1;	// prefetch took mem[ptr]
				state <= ST_IDLE;
			end

			if (accept) begin
				if (is_data && req.write) begin
					wr_pend <= 1'b1;	// array written next cycle
					ptr     <= ptr + 1'b1;
				end else if (is_data) begin
					rdata_en_q <= 1'b1;
					rdata_q    <= prefetch;
					state      <= ST_FETCH;
				end else if (req.write && !toggle) begin
					addr_lo <= req.wdata;
					toggle  <= 1'b1;
				end else if (req.write) begin
					toggle <= 1'b0;
					ptr    <= {req.wdata[1:0], addr_lo};
					if (!req.wdata[6]) begin
						state <= ST_FETCH;	// read setup, fill latch
					end
				end else begin
					rdata_en_q <= 1'b1;	// status stub
					rdata_q    <= 8'h00;
					toggle     <= 1'b0;
				end
			end
		end
	end

	// -----------------------------------------------
	// vram array, one write and one read port
	// -----------------------------------------------
	always_ff @(posedge clk) begin
		if (accept && is_data && req.write) begin
			wr_addr <= ptr;
			wr_data <= req.wdata;
		end
		if (wr_pend) begin
			mem[wr_addr] <= wr_data;
		end
		if (state == ST_FETCH) begin
			prefetch <= mem[ptr];
		end
	end

endmodule

`default_nettype wire

// File: verilog/vdp_cartridge.sv
// cartridge I/O top: bus control, GPIO with status LED, VRAM access port
// bus_req arrives already synchronised to clk
`timescale 1ns/1ps
`default_nettype none

module vdp_cartridge (
	input  wire                 clk,
	input  wire                 arst_n,
	input  wire cart_pkg::bus_req_t bus_req,
	output cart_pkg::bus_rsp_t  bus_rsp,
	output logic                ws2812_led
);

	cart_pkg::bus_req_t gpio_req;
	cart_pkg::bus_req_t vram_req;
	cart_pkg::bus_rsp_t gpio_rsp;
	cart_pkg::bus_rsp_t vram_rsp;
	cart_pkg::led_rgb_t led_color;
	logic               led_send;
	logic               led_busy;

	// -----------------------------------------------
	// port decode
	// -----------------------------------------------
	cart_bus_ctrl i_bus_ctrl (
		.clk      ( clk      ),
		.arst_n   ( arst_n   ),
		.bus_req  ( bus_req  ),
		.gpio_rsp ( gpio_rsp ),
		.vram_rsp ( vram_rsp ),
		.bus_rsp  ( bus_rsp  ),
		.gpio_req ( gpio_req ),
		.vram_req ( vram_req )
	);

	// -----------------------------------------------
	// status LED, ports 10h..13h
	// -----------------------------------------------
	cart_gpio i_gpio (
		.clk       ( clk       ),
		.arst_n    ( arst_n    ),
		.req       ( gpio_req  ),
		.led_busy  ( led_busy  ),
		.rsp       ( gpio_rsp  ),
		.led_send  ( led_send  ),
		.led_color ( led_color )
	);

	ws2812_tx i_ws2812 (
		.clk    ( clk        ),
		.arst_n ( arst_n     ),
		.send   ( led_send   ),
		.color  ( led_color  ),
		.busy   ( led_busy   ),
		.led    ( ws2812_led )
	);

	// -----------------------------------------------
	// vram access, ports 98h/99h
	// -----------------------------------------------
	vram_port i_vram (
		.clk    ( clk      ),
		.arst_n ( arst_n   ),
		.req    ( vram_req ),
		.rsp    ( vram_rsp )
	);

endmodule

`default_nettype wire

// File: verif/vdp_cartridge_chk.sv
// handshake checks on the cart_bus_ctrl slot side, attached with bind
// one read in flight at a time is assumed
`timescale 1ns/1ps
`default_nettype none

module vdp_cartridge_chk (
	input wire                     clk,
	input wire                     arst_n,
	input wire cart_pkg::bus_req_t bus_req,
	input wire cart_pkg::bus_rsp_t bus_rsp
);

	logic rd_acc;

	assign rd_acc = bus_req.valid & bus_rsp.ready & ~bus_req.write;	// read taken

	// strobe only right after an accepted read
	strobe_after_read: assert property (@(posedge clk) disable iff (!arst_n)
		bus_rsp.rdata_en |-> $past(rd_acc))
		else $error("rdata_en without an accepted read");

	read_gets_strobe: assert property (@(posedge clk) disable iff (!arst_n)
		rd_acc |=> bus_rsp.rdata_en)
		else $error("accepted read without rdata_en next cycle");

	// first cycle out of reset
	idle_after_reset: assert property (@(posedge clk)
		$rose(arst_n) |-> (bus_rsp.ready && !bus_rsp.rdata_en))
		else $error("bus not idle after reset release");

	idle_rdata_ff: assert property (@(posedge clk) disable iff (!arst_n)
		!bus_rsp.rdata_en |-> (bus_rsp.rdata == 8'hFF))
		else $error("rdata not FFh while rdata_en is low");

endmodule

bind cart_bus_ctrl vdp_cartridge_chk i_chk (
	.clk     ( clk     ),
	.arst_n  ( arst_n  ),
	.bus_req ( bus_req ),
	.bus_rsp ( bus_rsp )
);

`default_nettype wire

// File: verif/vdp_cartridge_tb.sv
// drives bus_req 1 ns after the rising edge and samples bus_rsp at the falling edge
// vram bytes never written are never read back; one LED frame is decoded per send
`timescale 1ns/1ps
`default_nettype none

module vdp_cartridge_tb;

	localparam int FRAME_CYC = 24 * cart_pkg::WS_TBIT + cart_pkg::WS_TLATCH;
	localparam int TIMEOUT   = 4 * FRAME_CYC + 20000;

	logic               clk = 1'b0;
	logic               arst_n;
	cart_pkg::bus_req_t bus_req;
	cart_pkg::bus_rsp_t bus_rsp;
	logic               ws2812_led;

	// -----------------------------------------------
	// reference model state
	// -----------------------------------------------
	cart_pkg::io_data_t   m_mem [0:(1 << cart_pkg::VRAM_AW) - 1];
	cart_pkg::vram_addr_t m_ptr;		// next byte for data port
	cart_pkg::io_data_t   m_pref;		// read-ahead byte
	cart_pkg::io_data_t   m_lo;
	logic                 m_toggle;
	cart_pkg::led_rgb_t   m_color;
	logic                 m_led_busy;
	logic                 m_frame_pend;	// frame expected on the LED line
	logic [23:0]          m_grb;

	cart_pkg::io_data_t exp_q [$];		// expected bytes in arrival order
	int                 cycles = 0;
	int                 frames_done = 0;
	int                 hi_cnt = 0;
	int                 n_bits = 0;
	logic [23:0]        bits;
	integer             seed;

	always #5 clk = ~clk;

	vdp_cartridge i_dut (
		.clk        ( clk        ),
		.arst_n     ( arst_n     ),
		.bus_req    ( bus_req    ),
		.bus_rsp    ( bus_rsp    ),
		.ws2812_led ( ws2812_led )
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	// expected byte for a read and the matching model update
	function automatic cart_pkg::io_data_t ref_read(input cart_pkg::io_addr_t addr);
		cart_pkg::io_data_t d;
		d = 8'hFF;	// unclaimed port
		case (addr)
			cart_pkg::GPIO_BASE:        d = m_color.red;
			cart_pkg::GPIO_BASE + 8'd1: d = m_color.green;
			cart_pkg::GPIO_BASE + 8'd2: d = m_color.blue;
			cart_pkg::GPIO_BASE + 8'd3: d = {7'd0, m_led_busy};
			cart_pkg::VDP_BASE: begin
				d      = m_pref;		// latch out first then refill
				m_pref = m_mem[m_ptr];
				m_ptr  = m_ptr + 1'b1;
			end
			cart_pkg::VDP_BASE + 8'd1: begin
				d        = 8'h00;		// status stub
				m_toggle = 1'b0;
			end
			default: d = 8'hFF;
		endcase
		return d;
	endfunction

	task automatic ref_write(input cart_pkg::io_addr_t addr, input cart_pkg::io_data_t d);
		case (addr)
			cart_pkg::GPIO_BASE:        m_color.red   = d;
			cart_pkg::GPIO_BASE + 8'd1: m_color.green = d;
			cart_pkg::GPIO_BASE + 8'd2: m_color.blue  = d;
			cart_pkg::GPIO_BASE + 8'd3: begin
				if (!m_led_busy) begin	// send while busy is dropped
					m_led_busy   = 1'b1;
					m_frame_pend = 1'b1;
					m_grb        = {m_color.green, m_color.red, m_color.blue};
				end
			end
			cart_pkg::VDP_BASE: begin
				m_mem[m_ptr] = d;
				m_ptr        = m_ptr + 1'b1;	// wraps at 1 KiB
			end
			cart_pkg::VDP_BASE + 8'd1: begin
				if (!m_toggle) begin
					m_lo     = d;
					m_toggle = 1'b1;
				end else begin
					m_toggle = 1'b0;
					m_ptr    = {d[1:0], m_lo};
					if (!d[6]) begin		// read setup fills the latch
						m_pref = m_mem[m_ptr];
						m_ptr  = m_ptr + 1'b1;
					end
				end
			end
			default: ;
		endcase
	endtask

	// -----------------------------------------------
	// bus tasks
	// -----------------------------------------------
	task automatic wait_accept();
		@(negedge clk);
		while (!bus_rsp.ready) begin
			@(negedge clk);
		end
		@(posedge clk);	// accepting edge
		#1;
		bus_req.valid = 1'b0;
	endtask

	task automatic bus_write(input cart_pkg::io_addr_t addr, input cart_pkg::io_data_t d);
		bus_req = '{valid: 1'b1, write: 1'b1, address: addr, wdata: d};
		wait_accept();
		ref_write(addr, d);
	endtask

	task automatic bus_read(input cart_pkg::io_addr_t addr);
		bus_req = '{valid: 1'b1, write: 1'b0, address: addr, wdata: 8'h00};
		wait_accept();
		exp_q.push_back(ref_read(addr));
		@(negedge clk);
		while (!bus_rsp.rdata_en) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	// valid held high over all reads so refill stalls show up
	task automatic read_burst(input int n);
		int cnt;
		int stalls;
		cnt    = 0;
		stalls = 0;
		bus_req = '{valid: 1'b1, write: 1'b0, address: cart_pkg::VDP_BASE, wdata: 8'h00};
		while (cnt < n) begin
			@(negedge clk);
			if (bus_rsp.ready) begin
				exp_q.push_back(ref_read(cart_pkg::VDP_BASE));
				cnt++;
			end else begin
				stalls++;
			end
			@(posedge clk);
			#1;
		end
		bus_req.valid = 1'b0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		assert (stalls > 0)
		else fail_run("back-to-back data reads never saw ready low");
	endtask

	task automatic set_vram_addr(input cart_pkg::vram_addr_t addr, input logic rd);
		bus_write(cart_pkg::VDP_BASE + 8'd1, addr[7:0]);
		bus_write(cart_pkg::VDP_BASE + 8'd1, {1'b0, ~rd, 4'd0, addr[9:8]});	// bit 6 = write
	endtask

	// -----------------------------------------------
	// read data compare
	// -----------------------------------------------
	always @(negedge clk) begin
		cart_pkg::io_data_t exp_byte;
		if (arst_n && bus_rsp.rdata_en) begin
			assert (exp_q.size() != 0)
			else fail_run("read data strobe with no read outstanding");
			exp_byte = exp_q.pop_front();
			assert (bus_rsp.rdata == exp_byte)
			else fail_run($sformatf("MISMATCH rdata expected %02h actual %02h",
			                        exp_byte, bus_rsp.rdata));
		end
	end

	// LED decoder where pulse width picks the bit
	always @(negedge clk) begin
		if (ws2812_led) begin
			hi_cnt++;
		end else if (hi_cnt != 0) begin
			assert (m_frame_pend)
			else fail_run("LED pulse outside an expected frame");
			assert (hi_cnt == cart_pkg::WS_T0H || hi_cnt == cart_pkg::WS_T1H)
			else fail_run($sformatf("LED high pulse of %0d cycles fits no bit", hi_cnt));
			bits   = {bits[22:0], hi_cnt > cart_pkg::WS_TBIT / 2};
			hi_cnt = 0;
			n_bits++;
			if (n_bits == 24) begin
				assert (bits == m_grb)
				else fail_run($sformatf("MISMATCH ws2812_led expected %06h actual %06h",
				                        m_grb, bits));
				n_bits       = 0;
				m_frame_pend = 1'b0;
				frames_done++;
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT) begin
			fail_run($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT));
		end
	end

	// -----------------------------------------------
	// test sequence
	// -----------------------------------------------
	initial begin
		cart_pkg::vram_addr_t base;
		logic [31:0]          rnd;
		int                   frames;
		seed         = 32'h5ad2;
		bus_req      = '0;
		arst_n       = 1'b0;
		m_ptr        = '0;
		m_toggle     = 1'b0;
		m_color      = '0;
		m_led_busy   = 1'b0;
		m_frame_pend = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// idle after reset
		@(negedge clk);
		assert (bus_rsp.ready && !bus_rsp.rdata_en && !ws2812_led)
		else fail_run("bus or LED not idle after reset");
		@(posedge clk);
		#1;
		bus_read(cart_pkg::GPIO_BASE + 8'd3);

		// colour registers and unclaimed ports
		for (int i = 0; i < 3; i++) begin
			rnd = $random(seed);
			bus_write(cart_pkg::GPIO_BASE + 8'(i), rnd[7:0]);
		end
		for (int i = 0; i < 3; i++) begin
			bus_read(cart_pkg::GPIO_BASE + 8'(i));
		end
		bus_write(8'h55, 8'hA5);
		bus_read(8'h00);
		bus_read(8'h55);

		// one LED frame
		frames = frames_done;
		bus_write(cart_pkg::GPIO_BASE + 8'd3, 8'h00);
		repeat (4) @(posedge clk);
		#1;
		bus_read(cart_pkg::GPIO_BASE + 8'd3);	// busy mid-frame
		while (frames_done == frames) begin
			@(negedge clk);
		end
		repeat (cart_pkg::WS_TBIT + cart_pkg::WS_TLATCH) @(posedge clk);
		#1;
		m_led_busy = 1'b0;
		bus_read(cart_pkg::GPIO_BASE + 8'd3);

		// write stream near the top that wraps past 3FFh
		rnd  = $random(seed);
		base = {6'b111110, rnd[3:0]};
		set_vram_addr(base, 1'b0);
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			bus_write(cart_pkg::VDP_BASE, rnd[7:0]);
		end
		set_vram_addr(base, 1'b1);
		for (int i = 0; i < 40; i++) begin
			bus_read(cart_pkg::VDP_BASE);
		end

		// lone setup byte then a 99h read to clear the toggle
		bus_write(cart_pkg::VDP_BASE + 8'd1, 8'h3C);
		bus_read(cart_pkg::VDP_BASE + 8'd1);
		set_vram_addr(base + 10'd7, 1'b1);
		for (int i = 0; i < 4; i++) begin
			bus_read(cart_pkg::VDP_BASE);
		end

		// refill back-pressure
		set_vram_addr(base, 1'b1);
		read_burst(16);

		repeat (4) @(posedge clk);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: vdp_cartridge.f
verilog/cart_pkg.sv
verilog/cart_bus_ctrl.sv
verilog/cart_gpio.sv
verilog/ws2812_tx.sv
verilog/vram_port.sv
verilog/vdp_cartridge.sv
verif/vdp_cartridge_chk.sv
verif/vdp_cartridge_tb.sv

// File: Makefile
# Verilator build and run of the cartridge testbench

VERILATOR ?= verilator
TOP       ?= vdp_cartridge_tb
FILELIST  ?= vdp_cartridge.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
